// File: Makefile
# Verilator build of the vector runtime monitor testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_rt_monitor
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and fail unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+include
logic/rt_pkg.sv
logic/rt_ctrl_fsm.sv
logic/rt_perf_counters.sv
logic/rt_snapshot_regs.sv
logic/rt_monitor_top.sv
verification/tb_rt_monitor.sv

// File: include/rt_defines.svh
// ##########################################################
// Width and size macros of the vector runtime monitor
// Counter width, stall event count, snapshot sequence width
// ##########################################################

`ifndef RT_DEFINES_SVH
`define RT_DEFINES_SVH

// Width of every runtime and stall counter
`define RT_CNT_W 64

// Stall events reported by the host core
// Bit 0 data-cache miss, bit 1 instruction-cache miss, bit 2 scoreboard full
`define RT_NR_EVT 3

// Width of the snapshot sequence number
`define RT_SEQ_W 16

`endif

// File: logic/rt_ctrl_fsm.sv
// ##########################################################
// Control FSM of the vector runtime monitor
// Counting enable, pending-update flag, capture strobe
// ##########################################################

`timescale 1ns/1ns

`include "rt_defines.svh"

module rt_ctrl_fsm import rt_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  // Vector instruction dispatched this cycle
  input  logic vreq_valid_i,
  // Accelerator has no work in flight
  input  logic v_idle_i,
  // Software enable of the measurement
  input  logic sw_cnt_en_i,
  // Level, high while counting
  output logic cnt_en_o,
  // Single-cycle strobe, take a snapshot of the counters
  output logic capture_o
);

  rt_state_e state_d, state_q;

  // Set once work was dispatched that has not been reported yet
  logic pending_d, pending_q;

  // Next state of the counting enable
  always_comb begin
    // Hold by default
    state_d = state_q;
    unique case (state_q)
      RT_OFF: begin
        // Start on the first dispatch that software allows
        if (vreq_valid_i && sw_cnt_en_i) begin
          state_d = RT_RUN;
        end
      end
      RT_RUN: begin
        // Stop only once software disabled it and the accelerator drained
        // A busy accelerator keeps the window open
        if (!sw_cnt_en_i && v_idle_i) begin
          state_d = RT_OFF;
        end
      end
      default: begin
        state_d = RT_OFF;
      end
    endcase
  end

  // Drain detect
  // All dispatched work is done and nothing new arrives in this cycle
  assign capture_o = pending_q & v_idle_i & ~vreq_valid_i;

  // Pending flag
  // Any dispatch arms it, enabled or not
  // A capture clears it; capture never coincides with a dispatch
  always_comb begin
    pending_d = pending_q;
    if (vreq_valid_i) begin
      pending_d = 1'b1;
    end else if (capture_o) begin
      pending_d = 1'b0;
    end
  end

  // Counters see the enable one cycle after the starting dispatch
  assign cnt_en_o = (state_q == RT_RUN);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= RT_OFF;
      pending_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
    end
  end

endmodule : rt_ctrl_fsm

// File: logic/rt_monitor_top.sv
// ##########################################################
// Top level of the vector runtime monitor
// Control FSM, counter bank and snapshot bank
// ##########################################################

`timescale 1ns/1ns

`include "rt_defines.svh"

module rt_monitor_top import rt_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Accelerator side
  input  logic    vreq_valid_i,
  input  logic    v_idle_i,
  // Software enable
  input  logic    sw_cnt_en_i,
  // Host stall events
  input  rt_evt_t stall_evt_i,
  // Live counters
  output rt_cnt_t cycle_cnt_o,
  output rt_cnt_t dcache_cnt_o,
  output rt_cnt_t icache_cnt_o,
  output rt_cnt_t sb_full_cnt_o,
  // Snapshot of the last finished window
  output rt_cnt_t runtime_o,
  output rt_cnt_t dcache_stall_o,
  output rt_cnt_t icache_stall_o,
  output rt_cnt_t sb_full_o,
  output rt_seq_t snap_seq_o
);

  // FSM to counter bank
  logic cnt_en;
  // FSM to snapshot bank
  logic capture;

  // Decides when counting runs and when results are final
  rt_ctrl_fsm i_rt_ctrl_fsm (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .vreq_valid_i(vreq_valid_i),
    .v_idle_i    (v_idle_i    ),
    .sw_cnt_en_i (sw_cnt_en_i ),
    .cnt_en_o    (cnt_en      ),
    .capture_o   (capture     )
  );

  // Runtime and stall accumulators
  rt_perf_counters i_rt_perf_counters (
    .clk_i        (clk_i        ),
    .rst_ni       (rst_ni       ),
    .cnt_en_i     (cnt_en       ),
    .stall_evt_i  (stall_evt_i  ),
    .cycle_cnt_o  (cycle_cnt_o  ),
    .dcache_cnt_o (dcache_cnt_o ),
    .icache_cnt_o (icache_cnt_o ),
    .sb_full_cnt_o(sb_full_cnt_o)
  );

  // Live counters feed the buffers straight from the output ports
  rt_snapshot_regs i_rt_snapshot_regs (
    .clk_i         (clk_i         ),
    .rst_ni        (rst_ni        ),
    .capture_i     (capture       ),
    .cycle_cnt_i   (cycle_cnt_o   ),
    .dcache_cnt_i  (dcache_cnt_o  ),
    .icache_cnt_i  (icache_cnt_o  ),
    .sb_full_cnt_i (sb_full_cnt_o ),
    .runtime_o     (runtime_o     ),
    .dcache_stall_o(dcache_stall_o),
    .icache_stall_o(icache_stall_o),
    .sb_full_o     (sb_full_o     ),
    .snap_seq_o    (snap_seq_o    )
  );

endmodule : rt_monitor_top

// File: logic/rt_perf_counters.sv
// ##########################################################
// Counter bank of the vector runtime monitor
// Cycle counter and one counter per host stall event
// ##########################################################

`timescale 1ns/1ns

`include "rt_defines.svh"

module rt_perf_counters import rt_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Counting window from the control FSM
  input  logic    cnt_en_i,
  // Host stall events of this cycle
  input  rt_evt_t stall_evt_i,
  // Elapsed cycles inside counting windows
  output rt_cnt_t cycle_cnt_o,
  // Stall cycles inside counting windows
  output rt_cnt_t dcache_cnt_o,
  output rt_cnt_t icache_cnt_o,
  output rt_cnt_t sb_full_cnt_o
);

  rt_cnt_t cycle_cnt_d, cycle_cnt_q;

  // One accumulator per event bit, same layout as rt_evt_t
  rt_cnt_t evt_cnt_d [`RT_NR_EVT];
  rt_cnt_t evt_cnt_q [`RT_NR_EVT];

  // Runtime counter, one per enabled cycle
  always_comb begin
    cycle_cnt_d = cycle_cnt_q;
    if (cnt_en_i) begin
      // Wraps at the counter width
      cycle_cnt_d = cycle_cnt_q + rt_cnt_t'(1);
    end
  end

  // Event counters, one per enabled cycle with the event bit set
  always_comb begin
    for (int unsigned i = 0; i < `RT_NR_EVT; i++) begin
      evt_cnt_d[i] = evt_cnt_q[i];
      if (cnt_en_i && stall_evt_i[i]) begin
        evt_cnt_d[i] = evt_cnt_q[i] + rt_cnt_t'(1);
      end
    end
  end

  // Cleared only by reset, never between windows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_cnt_q <= '0;
      for (int unsigned i = 0; i < `RT_NR_EVT; i++) begin
        evt_cnt_q[i] <= '0;
      end
    end else begin
      cycle_cnt_q <= cycle_cnt_d;
      for (int unsigned i = 0; i < `RT_NR_EVT; i++) begin
        evt_cnt_q[i] <= evt_cnt_d[i];
      end
    end
  end

  // Live values, before this cycle's increment
  assign cycle_cnt_o   = cycle_cnt_q;
  assign dcache_cnt_o  = evt_cnt_q[RT_EVT_DCACHE];
  assign icache_cnt_o  = evt_cnt_q[RT_EVT_ICACHE];
  assign sb_full_cnt_o = evt_cnt_q[RT_EVT_SBFULL];

endmodule : rt_perf_counters

// File: logic/rt_pkg.sv
// ##########################################################
// Shared types of the vector runtime monitor
// Counter, event and sequence vectors, control state enum
// ##########################################################

`include "rt_defines.svh"

package rt_pkg;

  // Counter value, live or buffered
  typedef logic [`RT_CNT_W-1:0] rt_cnt_t;

  // One bit per host stall event
  // Bit 0 data-cache miss
  // Bit 1 instruction-cache miss
  // Bit 2 scoreboard full
  typedef logic [`RT_NR_EVT-1:0] rt_evt_t;

  // Number of snapshots taken, wraps
  typedef logic [`RT_SEQ_W-1:0] rt_seq_t;

  // Counting state
  // RT_OFF waits for an enabled dispatch
  // RT_RUN counts until software disables and the accelerator drains
  typedef enum logic {
    RT_OFF = 1'b0,
    RT_RUN = 1'b1
  } rt_state_e;

  // Event bit positions inside rt_evt_t
  localparam int unsigned RT_EVT_DCACHE = 0;
  localparam int unsigned RT_EVT_ICACHE = 1;
  localparam int unsigned RT_EVT_SBFULL = 2;

endpackage : rt_pkg

// File: logic/rt_snapshot_regs.sv
// ##########################################################
// Snapshot bank of the vector runtime monitor
// Result buffers loaded on capture, snapshot sequence number
// ##########################################################

`timescale 1ns/1ns

`include "rt_defines.svh"

module rt_snapshot_regs import rt_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Drain strobe from the control FSM
  input  logic    capture_i,
  // Live counter values
  input  rt_cnt_t cycle_cnt_i,
  input  rt_cnt_t dcache_cnt_i,
  input  rt_cnt_t icache_cnt_i,
  input  rt_cnt_t sb_full_cnt_i,
  // Buffered results of the last finished window
  output rt_cnt_t runtime_o,
  output rt_cnt_t dcache_stall_o,
  output rt_cnt_t icache_stall_o,
  output rt_cnt_t sb_full_o,
  // Number of snapshots taken so far
  output rt_seq_t snap_seq_o
);

  rt_cnt_t runtime_buf_d, runtime_buf_q;
  rt_cnt_t dcache_buf_d, dcache_buf_q;
  rt_cnt_t icache_buf_d, icache_buf_q;
  rt_cnt_t sb_full_buf_d, sb_full_buf_q;
  rt_seq_t seq_d, seq_q;

  always_comb begin
    // Hold the last coherent set
    runtime_buf_d = runtime_buf_q;
    dcache_buf_d  = dcache_buf_q;
    icache_buf_d  = icache_buf_q;
    sb_full_buf_d = sb_full_buf_q;
    seq_d         = seq_q;
    // All four load together so the set always belongs to one window
    if (capture_i) begin
      runtime_buf_d = cycle_cnt_i;
      dcache_buf_d  = dcache_cnt_i;
      icache_buf_d  = icache_cnt_i;
      sb_full_buf_d = sb_full_cnt_i;
      // Lets software tell a fresh result from an old one, wraps
      seq_d         = seq_q + rt_seq_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      runtime_buf_q <= '0;
      dcache_buf_q  <= '0;
      icache_buf_q  <= '0;
      sb_full_buf_q <= '0;
      seq_q         <= '0;
    end else begin
      runtime_buf_q <= runtime_buf_d;
      dcache_buf_q  <= dcache_buf_d;
      icache_buf_q  <= icache_buf_d;
      sb_full_buf_q <= sb_full_buf_d;
      seq_q         <= seq_d;
    end
  end

  // New values appear one cycle after the strobe
  assign runtime_o      = runtime_buf_q;
  assign dcache_stall_o = dcache_buf_q;
  assign icache_stall_o = icache_buf_q;
  assign sb_full_o      = sb_full_buf_q;
  assign snap_seq_o     = seq_q;

endmodule : rt_snapshot_regs

// File: verification/tb_rt_monitor.sv
// ##########################################################
// Testbench of the vector runtime monitor
// Clock, reset, random dispatch and drain phases,
// cycle-level reference model, compare tasks, timeout
// ##########################################################

`timescale 1ns/1ns

`include "rt_defines.svh"

module tb_rt_monitor import rt_pkg::*; ();

  // Test length in cycles
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_PHASE   = 200;
  localparam int NR_WINDOWS   = 13;
  localparam int BURST        = 150;
  localparam int BUSY_TAIL    = 20;
  localparam int HOLD         = 20;
  // Drain takes at most a few cycles per window
  localparam int WINDOW_LEN   = BURST + BUSY_TAIL + HOLD + 4;
  localparam int TEST_CYCLES  = RESET_CYCLES + IDLE_PHASE + NR_WINDOWS * WINDOW_LEN + 4;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

  logic    clk_i;
  logic    rst_ni;
  logic    vreq_valid;
  logic    v_idle;
  logic    sw_cnt_en;
  rt_evt_t stall_evt;

  rt_cnt_t cycle_cnt;
  rt_cnt_t dcache_cnt;
  rt_cnt_t icache_cnt;
  rt_cnt_t sb_full_cnt;
  rt_cnt_t runtime;
  rt_cnt_t dcache_stall;
  rt_cnt_t icache_stall;
  rt_cnt_t sb_full;
  rt_seq_t snap_seq;

  integer seed;
  int     cycle_nr;

  // Reference model state
  rt_state_e m_state;
  logic      m_pend;
  rt_cnt_t   m_cyc;
  rt_cnt_t   m_evt [`RT_NR_EVT];
  rt_cnt_t   m_buf_cyc;
  rt_cnt_t   m_buf_evt [`RT_NR_EVT];
  rt_seq_t   m_seq;

  rt_monitor_top i_rt_monitor_top (
    .clk_i         (clk_i       ),
    .rst_ni        (rst_ni      ),
    .vreq_valid_i  (vreq_valid  ),
    .v_idle_i      (v_idle      ),
    .sw_cnt_en_i   (sw_cnt_en   ),
    .stall_evt_i   (stall_evt   ),
    .cycle_cnt_o   (cycle_cnt   ),
    .dcache_cnt_o  (dcache_cnt  ),
    .icache_cnt_o  (icache_cnt  ),
    .sb_full_cnt_o (sb_full_cnt ),
    .runtime_o     (runtime     ),
    .dcache_stall_o(dcache_stall),
    .icache_stall_o(icache_stall),
    .sb_full_o     (sb_full     ),
    .snap_seq_o    (snap_seq    )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic void reset_model();
    m_state   = RT_OFF;
    m_pend    = 1'b0;
    m_cyc     = '0;
    m_buf_cyc = '0;
    m_seq     = '0;
    for (int i = 0; i < `RT_NR_EVT; i++) begin
      m_evt[i]     = '0;
      m_buf_evt[i] = '0;
    end
  endfunction

  // One clock edge of the monitor from the inputs sampled at that edge
  function automatic void step_model(input logic vreq, input logic idle, input logic en,
                                     input rt_evt_t evt);
    logic capture;
    // Drain seen with no new dispatch
    capture = m_pend && idle && !vreq;
    // Buffers take the counters before this cycle's increment
    if (capture) begin
      m_buf_cyc = m_cyc;
      for (int i = 0; i < `RT_NR_EVT; i++) begin
        m_buf_evt[i] = m_evt[i];
      end
      m_seq = m_seq + rt_seq_t'(1);
    end
    if (m_state == RT_RUN) begin
      m_cyc = m_cyc + rt_cnt_t'(1);
      for (int i = 0; i < `RT_NR_EVT; i++) begin
        if (evt[i]) begin
          m_evt[i] = m_evt[i] + rt_cnt_t'(1);
        end
      end
    end
    if (m_state == RT_OFF && vreq && en) begin
      m_state = RT_RUN;
    end else if (m_state == RT_RUN && !en && idle) begin
      m_state = RT_OFF;
    end
    if (vreq) begin
      m_pend = 1'b1;
    end else if (capture) begin
      m_pend = 1'b0;
    end
  endfunction

  task automatic check_cnt(input string what, input rt_cnt_t got, input rt_cnt_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_seq(input string what, input rt_seq_t got, input rt_seq_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic compare_all();
    check_cnt("cycle count", cycle_cnt, m_cyc);
    check_cnt("dcache count", dcache_cnt, m_evt[RT_EVT_DCACHE]);
    check_cnt("icache count", icache_cnt, m_evt[RT_EVT_ICACHE]);
    check_cnt("sb full count", sb_full_cnt, m_evt[RT_EVT_SBFULL]);
    check_cnt("runtime buffer", runtime, m_buf_cyc);
    check_cnt("dcache stall buffer", dcache_stall, m_buf_evt[RT_EVT_DCACHE]);
    check_cnt("icache stall buffer", icache_stall, m_buf_evt[RT_EVT_ICACHE]);
    check_cnt("sb full buffer", sb_full, m_buf_evt[RT_EVT_SBFULL]);
    check_seq("snapshot sequence", snap_seq, m_seq);
  endtask

  // Step the model at each rising edge and compare at the falling edge
  initial begin
    forever begin
      @(posedge clk_i);
      if (!rst_ni) begin
        reset_model();
      end else begin
        step_model(vreq_valid, v_idle, sw_cnt_en, stall_evt);
      end
      @(negedge clk_i);
      compare_all();
    end
  end

  initial begin
    cycle_nr = 0;
    forever begin
      @(posedge clk_i);
      cycle_nr++;
      if (cycle_nr > TIMEOUT_CYCLES) begin
        $display("timeout: the test did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped by the cycle limit");
      end
    end
  end

  // True about once in one_in calls
  function automatic logic rand_bit(input int unsigned one_in);
    int unsigned r;
    r = $random(seed);
    return (r % one_in) == 0;
  endfunction

  // Inputs change 1 ns after the rising edge and events are random each cycle
  task automatic drive_cycle(input logic vreq, input logic idle, input logic en);
    @(posedge clk_i);
    #1;
    vreq_valid = vreq;
    v_idle     = idle;
    sw_cnt_en  = en;
    stall_evt  = rt_evt_t'($random(seed));
  endtask

  // One window with burst, busy tail, drain and hold
  task automatic run_window(input int nr);
    rt_seq_t seq_before;
    // Enabling dispatch opens the window
    drive_cycle(1'b1, 1'b0, 1'b1);
    for (int i = 1; i < BURST; i++) begin
      drive_cycle(rand_bit(2), 1'b0, 1'b1);
    end
    // Software disables while the accelerator is still busy
    for (int i = 0; i < BUSY_TAIL; i++) begin
      drive_cycle(rand_bit(4), 1'b0, 1'b0);
    end
    // Snapshots the model expects so far
    seq_before = m_seq;
    if (nr % 2 == 1) begin
      // Dispatch right as idle rises blocks the capture in that cycle
      drive_cycle(1'b1, 1'b1, 1'b0);
      drive_cycle(1'b0, 1'b1, 1'b0);
      check_seq("sequence after dispatch at idle", snap_seq, seq_before);
    end
    // Wait for the snapshot
    while (snap_seq == seq_before) begin
      drive_cycle(1'b0, 1'b1, 1'b0);
    end
    check_seq("sequence after drain", snap_seq, seq_before + rt_seq_t'(1));
    for (int i = 0; i < HOLD; i++) begin
      drive_cycle(1'b0, 1'b1, 1'b0);
    end
    // One snapshot per window
    check_seq("sequence after hold", snap_seq, seq_before + rt_seq_t'(1));
  endtask

  initial begin
    seed       = 32'h2f1a_d36b;
    rst_ni     = 1'b0;
    vreq_valid = 1'b0;
    v_idle     = 1'b1;
    sw_cnt_en  = 1'b0;
    stall_evt  = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Dispatches with software enable off must not count
    for (int i = 0; i < IDLE_PHASE; i++) begin
      drive_cycle(rand_bit(3), rand_bit(2), 1'b0);
    end
    check_cnt("cycle count with enable off", cycle_cnt, '0);
    for (int w = 0; w < NR_WINDOWS; w++) begin
      run_window(w);
    end
    // Let the last compare finish
    @(posedge clk_i);
    #6;
    $display("NO ERRORS");
    $finish;
  end

endmodule : tb_rt_monitor
